/* rtl/noc_pkg.sv */
package noc_pkg;

	localparam int mesh_dim = 3;
	localparam int num_routers = mesh_dim * mesh_dim;
	localparam int num_ports = 5;
	localparam int buf_depth = 4;
	localparam int buf_ptr_w = $clog2(buf_depth);

	typedef enum logic [2:0] {
		port_north,
		port_east,
		port_south,
		port_west,
		port_local
	} port_t;

	typedef logic [1:0] coord_t;
	// column in the upper half, row in the lower half.
	typedef logic [3:0] router_addr_t;
	typedef logic [31:0] payload_t;
	typedef logic [2:0] credit_t;
	typedef logic [num_ports-1:0] port_mask_t;
	typedef logic [buf_ptr_w-1:0] buf_ptr_t;

	function automatic coord_t addr_col(input router_addr_t addr);
		return addr[3:2];
	endfunction

	function automatic coord_t addr_row(input router_addr_t addr);
		return addr[1:0];
	endfunction

	function automatic router_addr_t make_addr(input coord_t col, input coord_t row);
		return {col, row};
	endfunction

	// index of the router on the far side of port p, or -1 at the mesh edge.
	function automatic int neighbor(input int r, input int p);
		int col;
		int row;
		col = r % mesh_dim;
		row = r / mesh_dim;
		if (p == port_north && row > 0)
			return r - mesh_dim;
		if (p == port_east && col < mesh_dim - 1)
			return r + 1;
		if (p == port_south && row < mesh_dim - 1)
			return r + mesh_dim;
		if (p == port_west && col > 0)
			return r - 1;
		return -1;
	endfunction

endpackage

/* rtl/link_if.sv */
`timescale 1ns/100ps

interface link_if import noc_pkg::*; ();

	logic         valid;
	router_addr_t dest;
	payload_t     payload;
	// one pulse per flit taken out of the receiving buffer.
	logic         credit;

	modport tx (
		output valid,
		output dest,
		output payload,
		input  credit
	);

	modport rx (
		input  valid,
		input  dest,
		input  payload,
		output credit
	);

endinterface

/* rtl/input_unit.sv */
`timescale 1ns/100ps

module input_unit import noc_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  router_addr_t my_addr,
	link_if.rx           in,
	output port_mask_t   req,
	output router_addr_t head_dest,
	output payload_t     head_payload,
	input  logic         grant,
	output logic         error
);

	router_addr_t dest_mem [buf_depth];
	payload_t     payload_mem [buf_depth];

	buf_ptr_t wr_ptr;
	buf_ptr_t rd_ptr;
	credit_t  count;
	logic     head_valid;
	logic     bad_addr;
	logic     pop;
	port_t    route;

	assign head_valid = (count != '0);
	assign head_dest = dest_mem[rd_ptr];
	assign head_payload = payload_mem[rd_ptr];

	// coordinate 3 lies outside the grid.
	assign bad_addr = (addr_col(head_dest) >= coord_t'(mesh_dim)) ||
		(addr_row(head_dest) >= coord_t'(mesh_dim));

	// dimension order routing, the column is resolved before the row.
	always_comb begin
		if (addr_col(head_dest) > addr_col(my_addr))
			route = port_east;
		else if (addr_col(head_dest) < addr_col(my_addr))
			route = port_west;
		else if (addr_row(head_dest) > addr_row(my_addr))
			route = port_south;
		else if (addr_row(head_dest) < addr_row(my_addr))
			route = port_north;
		else
			route = port_local;
	end

	always_comb begin
		req = '0;
		if (head_valid && !bad_addr)
			req[route] = 1'b1;
	end

	// a misaddressed head is discarded without ever asking for an output.
	assign pop = grant || (head_valid && bad_addr);

	always_ff @(posedge clk) begin
		if (in.valid) begin
			dest_mem[wr_ptr] <= in.dest;
			payload_mem[wr_ptr] <= in.payload;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			in.credit <= 1'b0;
			error <= 1'b0;
		end else begin
			if (in.valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + credit_t'(in.valid) - credit_t'(pop);
			in.credit <= pop;
			if (head_valid && bad_addr)
				error <= 1'b1;
		end
	end

	// the upstream credit counter must keep the sender off a full buffer.
	a_no_overflow: assert property (
		@(posedge clk) disable iff (!rst_n)
		in.valid |-> (count != credit_t'(buf_depth))
	) else $error("flit written into a full input buffer");

	// a granted head must still be waiting in the buffer.
	a_grant_has_head: assert property (
		@(posedge clk) disable iff (!rst_n)
		grant |-> head_valid && !bad_addr
	) else $error("input granted with no routable head flit");

endmodule

/* rtl/output_arbiter.sv */
`timescale 1ns/100ps

module output_arbiter import noc_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  port_mask_t   req,
	output port_mask_t   grant,
	input  router_addr_t flit_dest,
	input  payload_t     flit_payload,
	link_if.tx           out
);

	port_t   rr_ptr;
	port_t   sel;
	credit_t credits;
	logic    send;

	// round robin search that starts at the input after the last winner.
	always_comb begin
		port_t idx;
		grant = '0;
		sel = rr_ptr;
		for (int k = 0; k < num_ports; k++) begin
			idx = port_t'((int'(rr_ptr) + k) % num_ports);
			if (grant == '0 && req[idx] && credits != '0) begin
				grant[idx] = 1'b1;
				sel = idx;
			end
		end
	end

	assign send = |grant;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rr_ptr <= port_north;
			credits <= credit_t'(buf_depth);
			out.valid <= 1'b0;
		end else begin
			out.valid <= send;
			if (send)
				rr_ptr <= port_t'((int'(sel) + 1) % num_ports);
			credits <= credits - credit_t'(send) + credit_t'(out.credit);
		end
	end

	always_ff @(posedge clk) begin
		if (send) begin
			out.dest <= flit_dest;
			out.payload <= flit_payload;
		end
	end

	a_grant_onehot: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(grant)
	) else $error("more than one input granted on one output");

	// the receiver may only return credits it was given.
	a_credit_bound: assert property (
		@(posedge clk) disable iff (!rst_n)
		credits <= credit_t'(buf_depth)
	) else $error("credit count above buffer depth");

endmodule

/* rtl/mesh_router.sv */
`timescale 1ns/100ps

module mesh_router import noc_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  router_addr_t my_addr,
	link_if.rx           in_links [num_ports],
	link_if.tx           out_links [num_ports],
	output logic         error
);

	// req is indexed by input, out_req and out_grant by output.
	port_mask_t   req [num_ports];
	port_mask_t   out_req [num_ports];
	port_mask_t   out_grant [num_ports];
	router_addr_t head_dest [num_ports];
	payload_t     head_payload [num_ports];
	router_addr_t xb_dest [num_ports];
	payload_t     xb_payload [num_ports];
	port_mask_t   in_grant;
	port_mask_t   in_error;

	for (genvar p = 0; p < num_ports; p++) begin : g_port
		input_unit u_in (
			.clk          (clk),
			.rst_n        (rst_n),
			.my_addr      (my_addr),
			.in           (in_links[p]),
			.req          (req[p]),
			.head_dest    (head_dest[p]),
			.head_payload (head_payload[p]),
			.grant        (in_grant[p]),
			.error        (in_error[p])
		);

		output_arbiter u_arb (
			.clk          (clk),
			.rst_n        (rst_n),
			.req          (out_req[p]),
			.grant        (out_grant[p]),
			.flit_dest    (xb_dest[p]),
			.flit_payload (xb_payload[p]),
			.out          (out_links[p])
		);
	end

	always_comb begin
		for (int o = 0; o < num_ports; o++)
			for (int i = 0; i < num_ports; i++)
				out_req[o][i] = req[i][o];
	end

	// crossbar, each output takes the head flit of the input it granted.
	always_comb begin
		for (int o = 0; o < num_ports; o++) begin
			xb_dest[o] = '0;
			xb_payload[o] = '0;
			for (int i = 0; i < num_ports; i++) begin
				if (out_grant[o][i]) begin
					xb_dest[o] = head_dest[i];
					xb_payload[o] = head_payload[i];
				end
			end
		end
	end

	// an input requests one output at a time, so at most one grant returns.
	always_comb begin
		in_grant = '0;
		for (int i = 0; i < num_ports; i++)
			for (int o = 0; o < num_ports; o++)
				in_grant[i] = in_grant[i] | out_grant[o][i];
	end

	assign error = |in_error;

endmodule

/* rtl/mesh_3x3.sv */
`timescale 1ns/100ps

module mesh_3x3 import noc_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   in_valid,
	input  router_addr_t           in_dest,
	input  payload_t               in_payload,
	output logic                   in_credit,
	output logic                   out_valid,
	output router_addr_t           out_dest,
	output payload_t               out_payload,
	input  logic                   out_credit,
	output logic [num_routers-1:0] rtr_error
);

	// what each router output drives, and the credit each input returns.
	logic         tx_valid [num_routers][num_ports];
	router_addr_t tx_dest [num_routers][num_ports];
	payload_t     tx_payload [num_routers][num_ports];
	logic         rx_credit [num_routers][num_ports];

	for (genvar r = 0; r < num_routers; r++) begin : g_rtr
		link_if rin [num_ports] ();
		link_if rout [num_ports] ();

		for (genvar p = 0; p < num_ports; p++) begin : g_port
			localparam int nb = neighbor(r, p);
			// east faces west and north faces south.
			localparam int opp = (p + 2) % 4;

			assign tx_valid[r][p] = rout[p].valid;
			assign tx_dest[r][p] = rout[p].dest;
			assign tx_payload[r][p] = rout[p].payload;
			assign rx_credit[r][p] = rin[p].credit;

			if (nb >= 0) begin : g_link
				assign rin[p].valid = tx_valid[nb][opp];
				assign rin[p].dest = tx_dest[nb][opp];
				assign rin[p].payload = tx_payload[nb][opp];
				assign rout[p].credit = rx_credit[nb][opp];
			end else if (p == port_local && r == 0) begin : g_inject
				assign rin[p].valid = in_valid;
				assign rin[p].dest = in_dest;
				assign rin[p].payload = in_payload;
				assign rout[p].credit = 1'b0;
			end else if (p == port_local && r == num_routers - 1) begin : g_eject
				assign rin[p].valid = 1'b0;
				assign rin[p].dest = '0;
				assign rin[p].payload = '0;
				assign rout[p].credit = out_credit;
			end else begin : g_edge
				assign rin[p].valid = 1'b0;
				assign rin[p].dest = '0;
				assign rin[p].payload = '0;
				assign rout[p].credit = 1'b0;
			end
		end

		mesh_router u_rtr (
			.clk       (clk),
			.rst_n     (rst_n),
			.my_addr   (make_addr(coord_t'(r % mesh_dim), coord_t'(r / mesh_dim))),
			.in_links  (rin),
			.out_links (rout),
			.error     (rtr_error[r])
		);
	end

	assign in_credit = rx_credit[0][port_local];
	assign out_valid = tx_valid[num_routers-1][port_local];
	assign out_dest = tx_dest[num_routers-1][port_local];
	assign out_payload = tx_payload[num_routers-1][port_local];

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	localparam int half_period = 10;
	localparam int reset_cycles = 3;

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

/* dv/tb_mesh_3x3.sv */
`timescale 1ns/100ps

module tb_mesh_3x3 import noc_pkg::*; ();

	localparam logic [31:0] seed = 32'h97590474;
	localparam int wait_limit = 400;
	localparam int hold_window = 30;
	localparam int num_steps = 18;

	typedef struct packed {
		router_addr_t dest;
		payload_t     payload;
	} flit_t;

	// random_payload replaces the payload column with the next xorshift value.
	typedef struct packed {
		router_addr_t           dest;
		payload_t               payload;
		logic                   random_payload;
		logic                   hold;
		logic                   delivered;
		logic [num_routers-1:0] exp_error;
	} step_t;

	logic                   clk;
	logic                   rst_n;
	logic                   in_valid;
	router_addr_t           in_dest;
	payload_t               in_payload;
	logic                   in_credit;
	logic                   out_valid;
	router_addr_t           out_dest;
	payload_t               out_payload;
	logic                   out_credit;
	logic [num_routers-1:0] rtr_error;

	// 4'hA is column 2, row 2, the ejection router. column or row 3 is off the grid.
	step_t steps [num_steps] = '{
		'{4'hA, 32'h0000_0001, 1'b0, 1'b0, 1'b1, 9'h000},
		'{4'hA, 32'hDEAD_BEEF, 1'b0, 1'b0, 1'b1, 9'h000},
		'{4'hA, 32'h1234_5678, 1'b0, 1'b0, 1'b1, 9'h000},
		'{4'hF, 32'hBAD0_0001, 1'b0, 1'b0, 1'b0, 9'h001},
		'{4'hA, 32'hCAFE_F00D, 1'b0, 1'b0, 1'b1, 9'h001},
		'{4'hC, 32'hBAD0_0002, 1'b0, 1'b0, 1'b0, 9'h001},
		'{4'h3, 32'hBAD0_0003, 1'b0, 1'b0, 1'b0, 9'h001},
		'{4'hA, 32'h0000_0000, 1'b1, 1'b1, 1'b1, 9'h001},
		'{4'hA, 32'h0000_0000, 1'b1, 1'b1, 1'b1, 9'h001},
		'{4'hA, 32'h0000_0000, 1'b1, 1'b1, 1'b1, 9'h001},
		'{4'hA, 32'h0000_0000, 1'b1, 1'b1, 1'b1, 9'h001},
		'{4'hA, 32'h0000_0000, 1'b1, 1'b1, 1'b1, 9'h001},
		'{4'hA, 32'h0000_0000, 1'b1, 1'b1, 1'b1, 9'h001},
		'{4'hA, 32'h0000_0000, 1'b1, 1'b0, 1'b1, 9'h001},
		'{4'hA, 32'h0000_0000, 1'b1, 1'b0, 1'b1, 9'h001},
		'{4'hA, 32'h0000_0000, 1'b1, 1'b0, 1'b1, 9'h001},
		'{4'hA, 32'h0000_0000, 1'b1, 1'b0, 1'b1, 9'h001},
		'{4'hB, 32'hBAD0_0004, 1'b0, 1'b0, 1'b0, 9'h001}
	};

	flit_t       expected_q [$];
	int          errors = 0;
	int          timeouts = 0;
	int          sent_count = 0;
	int          credit_pulses = 0;
	int          rx_count = 0;
	int          sink_credits = buf_depth;
	int          owed = 0;
	logic        sink_hold;
	logic [31:0] rng_state;

	tb_clock_gen u_clk (
		.clk   (clk),
		.rst_n (rst_n)
	);

	mesh_3x3 u_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_dest     (in_dest),
		.in_payload  (in_payload),
		.in_credit   (in_credit),
		.out_valid   (out_valid),
		.out_dest    (out_dest),
		.out_payload (out_payload),
		.out_credit  (out_credit),
		.rtr_error   (rtr_error)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic compare_flit(input router_addr_t got_dest, input payload_t got_payload,
		input router_addr_t exp_dest, input payload_t exp_payload);
		if (got_dest !== exp_dest || got_payload !== exp_payload) begin
			errors++;
			$display("** Error at %0t ns: flit dest %h payload %h, expected dest %h payload %h",
				$time, got_dest, got_payload, exp_dest, exp_payload);
		end
	endtask

	task automatic compare_error(input logic [num_routers-1:0] got,
		input logic [num_routers-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: rtr_error is %b, expected %b", $time, got, exp);
		end
	endtask

	task automatic compare_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic compare_count(input int got, input int exp, input string what);
		if (got != exp) begin
			errors++;
			$display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic wait_reset();
		int waited;
		waited = 0;
		while (!rst_n && waited < wait_limit) begin
			waited++;
			@(negedge clk);
		end
		if (!rst_n) begin
			timeouts++;
			$display("timeout: rst_n was never released");
		end
	endtask

	task automatic send_flit(input router_addr_t dest, input payload_t payload);
		int waited;
		waited = 0;
		@(posedge clk);
		while (sent_count - credit_pulses >= buf_depth && waited < wait_limit) begin
			waited++;
			@(posedge clk);
		end
		if (sent_count - credit_pulses >= buf_depth) begin
			timeouts++;
			$display("timeout: in_credit never came back, the flit to %h was not sent", dest);
		end else begin
			in_valid <= 1'b1;
			in_dest <= dest;
			in_payload <= payload;
			sent_count++;
			@(posedge clk);
			in_valid <= 1'b0;
		end
	endtask

	task automatic wait_error_bit();
		int waited;
		waited = 0;
		@(negedge clk);
		while (!rtr_error[0] && waited < wait_limit) begin
			waited++;
			@(negedge clk);
		end
		if (!rtr_error[0]) begin
			timeouts++;
			$display("timeout: rtr_error bit 0 never rose after an out-of-grid flit");
		end
	endtask

	task automatic drain_flits();
		int waited;
		waited = 0;
		while (expected_q.size() != 0 && waited < wait_limit) begin
			waited++;
			@(posedge clk);
		end
		if (expected_q.size() != 0) begin
			timeouts++;
			$display("timeout: %0d flits never reached out_*", expected_q.size());
		end
	endtask

	task automatic release_sink(input int start_rx);
		int waited;
		waited = 0;
		while (rx_count - start_rx < buf_depth && waited < wait_limit) begin
			waited++;
			@(posedge clk);
		end
		if (rx_count - start_rx < buf_depth) begin
			timeouts++;
			$display("timeout: router 8 never used up its credits while the sink held them");
		end
		// a fifth flit would only show up after the last credit is gone.
		repeat (hold_window) @(posedge clk);
		compare_count(rx_count - start_rx, buf_depth, "flits delivered while out_credit was held");
		sink_hold <= 1'b0;
	endtask

	// sink and credit monitor. outputs are sampled on the falling edge.
	initial begin
		flit_t exp_flit;
		out_credit = 1'b0;
		forever begin
			@(negedge clk);
			if (rst_n) begin
				if (in_credit)
					credit_pulses++;
				if (credit_pulses > sent_count) begin
					errors++;
					$display("in_credit returned more credits than flits were sent");
				end
				if (out_valid) begin
					rx_count++;
					owed++;
					if (sink_credits == 0) begin
						errors++;
						$display("a flit reached out_* while the sink had no credit out");
					end else begin
						sink_credits--;
					end
					if (expected_q.size() == 0) begin
						errors++;
						$display("** Error at %0t ns: flit to %h payload %h was not expected",
							$time, out_dest, out_payload);
					end else begin
						exp_flit = expected_q.pop_front();
						compare_flit(out_dest, out_payload, exp_flit.dest, exp_flit.payload);
					end
				end
			end
			@(posedge clk);
			if (!sink_hold && owed > 0) begin
				out_credit <= 1'b1;
				owed--;
				sink_credits++;
			end else begin
				out_credit <= 1'b0;
			end
		end
	end

	initial begin
		step_t    st;
		flit_t    exp_flit;
		payload_t payload;
		int       hold_start;
		logic     holding;
		in_valid = 1'b0;
		in_dest = '0;
		in_payload = '0;
		sink_hold = 1'b0;
		holding = 1'b0;
		hold_start = 0;
		rng_state = seed;
		wait_reset();
		@(negedge clk);
		compare_bit(out_valid, 1'b0, "out_valid after reset");
		compare_bit(in_credit, 1'b0, "in_credit after reset");
		compare_error(rtr_error, '0);
		for (int i = 0; i < num_steps; i++) begin
			st = steps[i];
			if (st.hold && !holding) begin
				drain_flits();
				hold_start = rx_count;
				sink_hold <= 1'b1;
			end else if (!st.hold && holding) begin
				release_sink(hold_start);
			end
			holding = st.hold;
			payload = st.payload;
			if (st.random_payload) begin
				rng_state = xorshift32(rng_state);
				payload = rng_state;
			end
			if (st.delivered) begin
				exp_flit.dest = st.dest;
				exp_flit.payload = payload;
				expected_q.push_back(exp_flit);
			end
			send_flit(st.dest, payload);
			if (!st.delivered)
				wait_error_bit();
			@(negedge clk);
			compare_error(rtr_error, st.exp_error);
		end
		if (holding)
			release_sink(hold_start);
		drain_flits();
		compare_count(credit_pulses, sent_count, "in_credit pulses against flits sent");
		@(negedge clk);
		compare_error(rtr_error, steps[num_steps-1].exp_error);
		compare_bit(out_valid, 1'b0, "out_valid after the last flit");
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* flist.f */
rtl/noc_pkg.sv
rtl/link_if.sv
rtl/input_unit.sv
rtl/output_arbiter.sv
rtl/mesh_router.sv
rtl/mesh_3x3.sv
dv/tb_clock_gen.sv
dv/tb_mesh_3x3.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mesh_3x3 -f flist.f
	@out="$$(./obj_dir/Vtb_mesh_3x3)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^Testbench passed$$'

clean:
	rm -rf obj_dir
